// File: design/bcdToBinary.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module bcdToBinary (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic [`DIGITS_ALIGNED*4-1:0] bcdIn,
	input  logic signIn,
	input  dfpPkg::convFlags flagsIn,
	output logic [`BIN_WIDTH-1:0] binOut,
	output logic signOut,
	output dfpPkg::convFlags flagsOut,
	output logic convDone,
	output logic busy
);

	localparam int BcdBits = `DIGITS_ALIGNED*4;

	// remaining digits, next one in the top nibble
	logic [BcdBits-1:0] digitShift;
	// digits still to fold in after the load edge
	logic [4:0] digitCount;
	logic running;

	// ============================================================
	// sequencing
	// ============================================================

	// load takes the first digit, 19 more edges take the rest
	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			digitCount <= '0;
			convDone <= 1'b0;
		end else begin
			convDone <= 1'b0;
			if (load) begin
				running <= 1'b1;
				digitCount <= 5'(`DIGITS_ALIGNED - 1);
			end else if (running) begin
				digitCount <= digitCount - 5'd1;
				// last digit goes in on this edge
				if (digitCount == 5'd1) begin
					running <= 1'b0;
					convDone <= 1'b1;
				end
			end
		end
	end

	// ============================================================
	// accumulator, acc = acc * 10 + digit
	// ============================================================
	always_ff @(posedge clk) begin
		if (load) begin
			binOut <= `BIN_WIDTH'(bcdIn[BcdBits-1 -: 4]);
			digitShift <= {bcdIn[BcdBits-5:0], 4'h0};
			signOut <= signIn;
			flagsOut <= flagsIn;
		end else if (running) begin
			// times ten as times eight plus times two
			binOut <= (binOut << 3) + (binOut << 1) + `BIN_WIDTH'(digitShift[BcdBits-1 -: 4]);
			digitShift <= digitShift << 4;
		end
	end

	// busy from the aligner capture to the saturate register
	assign busy = load || running || convDone;

endmodule

// File: design/convControlRegs.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module convControlRegs (
	input  logic clk,
	input  logic reset,
	input  logic cfgWrite,
	input  logic [1:0] cfgAddr,
	input  logic [31:0] cfgWdata,
	input  logic done,
	input  dfpPkg::convFlags flags,
	output logic [31:0] cfgRdata,
	output logic signedMode,
	output logic roundHalf
);
	import dfpPkg::*;

	// sticky copy of every flag seen on done
	convFlags stickyFlags;
	// write-one-to-clear mask for this cycle
	convFlags clearMask;
	// completed conversions, wraps at 16 bits
	logic [15:0] convCount;

	assign clearMask = (cfgWrite && cfgAddr == `REG_STATUS) ? convFlags'(cfgWdata[1:0]) : '0;

	// ============================================================
	// mode, status and count registers
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			signedMode <= 1'b0;
			roundHalf <= 1'b0;
			stickyFlags <= '0;
			convCount <= '0;
		end else begin
			// bit 0 picks signed, bit 1 picks round half away from zero
			if (cfgWrite && cfgAddr == `REG_MODE) begin
				signedMode <= cfgWdata[0];
				roundHalf <= cfgWdata[1];
			end
			// a flag raised by this done wins over a clear in the same cycle
			stickyFlags <= (stickyFlags & ~clearMask) | (done ? flags : '0);
			if (done) begin
				convCount <= convCount + 16'd1;
			end
		end
	end

	// read mux, combinational from the address
	always_comb begin
		case (cfgAddr)
			`REG_MODE:   cfgRdata = {30'd0, roundHalf, signedMode};
			`REG_STATUS: cfgRdata = {30'd0, stickyFlags};
			`REG_COUNT:  cfgRdata = {16'd0, convCount};
			default:     cfgRdata = 32'd0;
		endcase
	end

endmodule

// File: design/dfpDigitAligner.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module dfpDigitAligner (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  dfpPkg::dfpWord operand,
	input  logic signedMode,
	input  logic roundHalf,
	input  logic busy,
	output logic alignValid,
	output logic [`DIGITS_ALIGNED*4-1:0] alignBcd,
	output logic alignSign,
	output dfpPkg::convFlags alignFlags
);
	import dfpPkg::*;

	localparam int OutBits = `DIGITS_ALIGNED*4;
	localparam int InBits = `DIGITS_IN*4;

	// add one to a BCD magnitude, rippling the decimal carry
	function automatic logic [OutBits-1:0] bcdIncrement(input logic [OutBits-1:0] value);
		logic [OutBits-1:0] sum;
		logic carry;
		carry = 1'b1;
		sum = value;
		for (int i = 0; i < `DIGITS_ALIGNED; i++) begin
			if (carry) begin
				if (value[i*4 +: 4] == 4'd9) begin
					sum[i*4 +: 4] = 4'd0;
				end else begin
					sum[i*4 +: 4] = value[i*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return sum;
	endfunction

	logic accept;
	logic isSpecial;
	logic isNaN;
	logic isInf;
	// signed digit shift, exponent minus bias
	logic signed [12:0] scale;
	logic [12:0] negScale;
	// 32 digits wide, room for 13 digits moved up by 19
	logic [127:0] upWide;
	logic [InBits-1:0] downKept;
	logic [InBits-1:0] roundSource;
	logic [OutBits-1:0] magnitude;
	logic shiftOverflow;
	convFlags flagsNext;

	assign accept = start && !busy;

	// ============================================================
	// decode, shift and round
	// ============================================================
	always_comb begin
		isSpecial = operand.finite.exponent == `EXP_SPECIAL;
		isNaN = isSpecial && operand.special.quiet;
		isInf = isSpecial && !operand.special.quiet;
		scale = 13'(operand.finite.exponent) - 13'(`DFP_BIAS);
		negScale = -scale;
		upWide = 128'(operand.finite.digits) << {scale[4:0], 2'b00};
		downKept = operand.finite.digits >> {negScale[3:0], 2'b00};
		// rounding digit is the most significant one dropped
		roundSource = operand.finite.digits >> {negScale[3:0] - 4'd1, 2'b00};
		shiftOverflow = 1'b0;
		magnitude = '0;
		if (isSpecial) begin
			magnitude = '0;
		end else if (!scale[12]) begin
			// scale 20 or more pushes every nonzero digit out
			if (scale > 13'sd19) begin
				shiftOverflow = operand.finite.digits != '0;
			end else begin
				shiftOverflow = upWide[127:OutBits] != '0;
				magnitude = upWide[OutBits-1:0];
			end
		end else if (scale >= -13'sd13) begin
			magnitude = OutBits'(downKept);
			if (roundHalf && roundSource[3:0] >= 4'd5) begin
				magnitude = bcdIncrement(magnitude);
			end
		end
		// out of range clamps to all nines, saturate stage takes the limit
		if (isInf || shiftOverflow) begin
			magnitude = {`DIGITS_ALIGNED{4'h9}};
		end
		flagsNext.invalid = isNaN;
		// negative nonzero cannot be held unsigned
		flagsNext.overflow = isInf || shiftOverflow
			|| (!signedMode && operand.finite.sign && !isNaN && magnitude != '0);
	end

	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			alignValid <= 1'b0;
		end else begin
			alignValid <= accept;
		end
	end

	// payload, captured on an accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			alignBcd <= magnitude;
			alignSign <= operand.finite.sign;
			alignFlags <= flagsNext;
		end
	end

endmodule

// File: design/dfpPkg.sv
`include "dfpToInt_macros.svh"

package dfpPkg;

	// ============================================================
	// decimal word, two decodings of the same 64 bits
	// ============================================================

	// finite view, 13 plain BCD digits with the most significant first
	typedef struct packed {
		logic sign;
		logic [`EXP_WIDTH-1:0] exponent;
		logic [`DIGITS_IN*4-1:0] digits;
	} dfpFinite;

	// special view, marker holds all ones
	// quiet set is NaN, quiet clear is infinity
	typedef struct packed {
		logic sign;
		logic [`EXP_WIDTH-1:0] marker;
		logic quiet;
		logic [`DFP_WIDTH-`EXP_WIDTH-3:0] payload;
	} dfpSpecial;

	typedef union packed {
		dfpFinite finite;
		dfpSpecial special;
	} dfpWord;

	// ============================================================
	// conversion flags, carried down the pipe
	// ============================================================

	// overflow sits in bit 1, invalid in bit 0
	typedef struct packed {
		logic overflow;
		logic invalid;
	} convFlags;

endpackage

// File: design/dfpToInt.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module dfpToInt (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  dfpPkg::dfpWord operand,
	input  logic cfgWrite,
	input  logic [1:0] cfgAddr,
	input  logic [31:0] cfgWdata,
	output logic [31:0] cfgRdata,
	output logic [`INT_WIDTH-1:0] result,
	output logic overflow,
	output logic invalid,
	output logic done,
	output logic busy
);
	import dfpPkg::*;

	// mode bits
	logic signedMode;
	logic roundHalf;

	// aligner to converter
	logic alignValid;
	logic [`DIGITS_ALIGNED*4-1:0] alignBcd;
	logic alignSign;
	convFlags alignFlags;

	// converter to saturate
	logic [`BIN_WIDTH-1:0] binValue;
	logic binSign;
	convFlags binFlags;
	logic convDone;

	// ============================================================
	// register block
	// ============================================================
	convControlRegs regs0 (
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgWdata(cfgWdata),
		.done(done),
		.flags({overflow, invalid}),
		.cfgRdata(cfgRdata),
		.signedMode(signedMode),
		.roundHalf(roundHalf)
	);

	// ============================================================
	// datapath, align then convert then saturate
	// ============================================================
	dfpDigitAligner align0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.operand(operand),
		.signedMode(signedMode),
		.roundHalf(roundHalf),
		.busy(busy),
		.alignValid(alignValid),
		.alignBcd(alignBcd),
		.alignSign(alignSign),
		.alignFlags(alignFlags)
	);

	bcdToBinary conv0 (
		.clk(clk),
		.reset(reset),
		.load(alignValid),
		.bcdIn(alignBcd),
		.signIn(alignSign),
		.flagsIn(alignFlags),
		.binOut(binValue),
		.signOut(binSign),
		.flagsOut(binFlags),
		.convDone(convDone),
		.busy(busy)
	);

	intSaturate sat0 (
		.clk(clk),
		.reset(reset),
		.valid(convDone),
		.magnitude(binValue),
		.sign(binSign),
		.flagsIn(binFlags),
		.signedMode(signedMode),
		.result(result),
		.overflow(overflow),
		.invalid(invalid),
		.done(done)
	);

endmodule

// File: design/dfpToInt_macros.svh
`ifndef DFP_TO_INT_MACROS_SVH
`define DFP_TO_INT_MACROS_SVH

// ============================================================
// word and datapath sizes
// ============================================================
`define DFP_WIDTH       64
`define EXP_WIDTH       11
`define DIGITS_IN       13
`define DIGITS_ALIGNED  20
`define BIN_WIDTH       68
`define INT_WIDTH       64

// value = digits * 10^(exponent - bias)
`define DFP_BIAS        398
// exponent of all ones marks infinity or NaN
`define EXP_SPECIAL     11'h7ff

// edges from the start sample to done
`define CONV_LATENCY    22

// configuration register addresses
`define REG_MODE        2'd0
`define REG_STATUS      2'd1
`define REG_COUNT       2'd2

`endif

// File: design/intSaturate.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module intSaturate (
	input  logic clk,
	input  logic reset,
	input  logic valid,
	input  logic [`BIN_WIDTH-1:0] magnitude,
	input  logic sign,
	input  dfpPkg::convFlags flagsIn,
	input  logic signedMode,
	output logic [`INT_WIDTH-1:0] result,
	output logic overflow,
	output logic invalid,
	output logic done
);

	// largest magnitude allowed for this mode and sign
	logic [`BIN_WIDTH-1:0] limit;
	logic [`INT_WIDTH-1:0] value;
	logic overflowNext;

	// ============================================================
	// range check and sign
	// ============================================================
	always_comb begin
		if (!signedMode) begin
			limit = {{(`BIN_WIDTH-`INT_WIDTH){1'b0}}, {`INT_WIDTH{1'b1}}};
		end else if (sign) begin
			limit = `BIN_WIDTH'(1) << (`INT_WIDTH - 1);
		end else begin
			limit = (`BIN_WIDTH'(1) << (`INT_WIDTH - 1)) - `BIN_WIDTH'(1);
		end
		overflowNext = 1'b0;
		value = magnitude[`INT_WIDTH-1:0];
		if (flagsIn.invalid) begin
			// NaN
			value = '0;
		end else if (!signedMode && sign && (magnitude != '0 || flagsIn.overflow)) begin
			// negative in unsigned mode
			value = '0;
			overflowNext = 1'b1;
		end else if (flagsIn.overflow || magnitude > limit) begin
			value = limit[`INT_WIDTH-1:0];
			overflowNext = 1'b1;
		end
		// two's complement, the negative limit maps onto itself
		// zero stays zero
		if (signedMode && sign) begin
			value = -value;
		end
	end

	// done strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= valid;
		end
	end

	// held until the next conversion completes
	always_ff @(posedge clk) begin
		if (valid) begin
			result <= value;
			overflow <= overflowNext;
			invalid <= flagsIn.invalid;
		end
	end

endmodule

// File: dv/dfpToIntRef.svh
`ifndef DFP_TO_INT_REF_SVH
`define DFP_TO_INT_REF_SVH

// ============================================================
// expected record and random source
// ============================================================

// one pending conversion, startCycle is the drive cycle of start
typedef struct packed {
	logic [63:0] value;
	logic overflow;
	logic invalid;
	logic [31:0] startCycle;
} expectRec;

logic [31:0] lcgState;

function automatic logic [31:0] lcgNext(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// finite word, scale is the power of ten applied to the digits
function automatic dfpWord makeWord(input logic sign, input int scale, input logic [51:0] digits);
	dfpWord w;
	w.finite.sign = sign;
	w.finite.exponent = 11'(scale + `DFP_BIAS);
	w.finite.digits = digits;
	return w;
endfunction

// quiet set gives NaN, clear gives infinity
function automatic dfpWord makeSpecial(input logic sign, input logic quiet);
	dfpWord w;
	w.special.sign = sign;
	w.special.marker = `EXP_SPECIAL;
	w.special.quiet = quiet;
	// payload bits carry no meaning here
	w.special.payload = 51'h5a5;
	return w;
endfunction

// 0 to 13 random digits, scale from -20 to 19
function automatic dfpWord randomFinite();
	logic [51:0] digits;
	int count;
	int scale;
	logic sign;
	digits = '0;
	lcgState = lcgNext(lcgState);
	count = int'(lcgState[31:24] % 8'd14);
	scale = int'(lcgState[23:16] % 8'd40) - 20;
	sign = lcgState[15];
	for (int i = 0; i < count; i++) begin
		lcgState = lcgNext(lcgState);
		digits[i*4 +: 4] = 4'(lcgState[31:24] % 8'd10);
	end
	return makeWord(sign, scale, digits);
endfunction

function automatic logic [127:0] pow10(input int n);
	logic [127:0] p;
	p = 128'd1;
	for (int i = 0; i < n; i++) begin
		p = p * 128'd10;
	end
	return p;
endfunction

// ============================================================
// reference conversion in 128-bit integer arithmetic
// ============================================================
function automatic expectRec refConvert(input dfpWord word, input logic sgn, input logic rnd);
	expectRec rec;
	logic [127:0] digitsVal;
	logic [127:0] mag;
	logic [127:0] pow;
	logic [127:0] rem;
	logic [127:0] limit;
	int scale;
	logic ovf;
	logic neg;
	rec = '0;
	mag = '0;
	ovf = 1'b0;
	neg = word.finite.sign;
	digitsVal = '0;
	for (int i = 12; i >= 0; i--) begin
		digitsVal = digitsVal * 128'd10 + 128'(word.finite.digits[i*4 +: 4]);
	end
	scale = int'(word.finite.exponent) - `DFP_BIAS;
	if (word.finite.exponent == `EXP_SPECIAL) begin
		rec.invalid = word.special.quiet;
		ovf = !word.special.quiet;
	end else if (scale > 19) begin
		ovf = digitsVal != '0;
	end else if (scale >= 0) begin
		mag = digitsVal * pow10(scale);
		// more than 20 integer digits
		ovf = mag >= pow10(20);
	end else if (scale >= -13) begin
		pow = pow10(-scale);
		mag = digitsVal / pow;
		rem = digitsVal % pow;
		// half away from zero acts on the magnitude
		if (rnd && rem * 128'd2 >= pow) begin
			mag = mag + 128'd1;
		end
	end
	if (!sgn) begin
		limit = (128'd1 << 64) - 128'd1;
	end else if (neg) begin
		limit = 128'd1 << 63;
	end else begin
		limit = (128'd1 << 63) - 128'd1;
	end
	if (rec.invalid) begin
		rec.value = '0;
	end else if (!sgn && neg && (mag != '0 || ovf)) begin
		rec.overflow = 1'b1;
	end else if (ovf || mag > limit) begin
		rec.value = limit[63:0];
		rec.overflow = 1'b1;
	end else begin
		rec.value = mag[63:0];
	end
	if (sgn && neg) begin
		rec.value = -rec.value;
	end
	return rec;
endfunction

`endif

// File: dv/dfpToIntTb.sv
`timescale 1ns/1ps
`include "dfpToInt_macros.svh"

module dfpToIntTb;
	import dfpPkg::*;

	localparam int RandomCount = 200;
	// directed conversions rounded up
	localparam int DirectedCount = 30;
	localparam int TimeoutCycles = (RandomCount + DirectedCount) * 30 + 200;

	logic clk;
	logic reset;
	logic start;
	dfpWord operand;
	logic cfgWrite;
	logic [1:0] cfgAddr;
	logic [31:0] cfgWdata;
	logic [31:0] cfgRdata;
	logic [63:0] result;
	logic overflow;
	logic invalid;
	logic done;
	logic busy;

	`include "dfpToIntRef.svh"

	// scoreboard state
	expectRec expectQ[$];
	int cycleCount = 0;
	// conversions handed to the DUT, each one accepted
	int issuedCount = 0;
	logic [1:0] stickyExp;
	logic modeSigned;
	logic modeRound;

	dfpToInt dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// cycle counter and run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		assert (cycleCount < TimeoutCycles)
			else reportFail($sformatf("timeout, run did not end within %0d cycles", TimeoutCycles));
	end

	// ============================================================
	// scoreboard with one expected record per done
	// ============================================================
	always @(negedge clk) begin : compareResults
		expectRec want;
		if (!reset && done) begin
			assert (expectQ.size() > 0) else reportFail("done pulsed with no conversion pending");
			want = expectQ.pop_front();
			assert (result === want.value) else reportFail($sformatf(
				"mismatch at %0t: result got %h expected %h", $time, result, want.value));
			assert (overflow === want.overflow) else reportFail($sformatf(
				"mismatch at %0t: overflow got %b expected %b", $time, overflow, want.overflow));
			assert (invalid === want.invalid) else reportFail($sformatf(
				"mismatch at %0t: invalid got %b expected %b", $time, invalid, want.invalid));
			// edges from the start drive to done
			assert (cycleCount - int'(want.startCycle) == `CONV_LATENCY) else reportFail($sformatf(
				"mismatch at %0t: done latency got %0d expected %0d", $time,
				cycleCount - int'(want.startCycle), `CONV_LATENCY));
		end
	end

	// all tasks start and end on a falling edge
	task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
		cfgWrite = 1'b1;
		cfgAddr = addr;
		cfgWdata = data;
		@(negedge clk);
		cfgWrite = 1'b0;
	endtask

	task automatic readCheck(input logic [1:0] addr, input logic [31:0] want, input string name);
		cfgAddr = addr;
		@(negedge clk);
		assert (cfgRdata === want) else reportFail($sformatf(
			"mismatch at %0t: cfgRdata(%s) got %h expected %h", $time, name, cfgRdata, want));
	endtask

	task automatic setMode(input logic sgn, input logic rnd);
		writeReg(`REG_MODE, {30'd0, rnd, sgn});
		modeSigned = sgn;
		modeRound = rnd;
		readCheck(`REG_MODE, {30'd0, rnd, sgn}, "mode");
	endtask

	// write-one-to-clear on the sticky flags
	task automatic clearStatus(input logic [1:0] mask);
		writeReg(`REG_STATUS, {30'd0, mask});
		stickyExp = stickyExp & ~mask;
		readCheck(`REG_STATUS, {30'd0, stickyExp}, "status");
	endtask

	task automatic issueStart(input dfpWord word, output expectRec rec);
		while (busy) @(negedge clk);
		rec = refConvert(word, modeSigned, modeRound);
		rec.startCycle = cycleCount;
		start = 1'b1;
		operand = word;
		expectQ.push_back(rec);
		issuedCount = issuedCount + 1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic runConv(input dfpWord word);
		expectRec rec;
		issueStart(word, rec);
		while (!done) @(negedge clk);
		stickyExp = stickyExp | {rec.overflow, rec.invalid};
	endtask

	initial begin
		expectRec rec;
		int countBefore;
		lcgState = 32'hced7_a6c5;
		stickyExp = 2'b00;
		modeSigned = 1'b0;
		modeRound = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		operand = '0;
		cfgWrite = 1'b0;
		cfgAddr = 2'd0;
		cfgWdata = 32'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (done === 1'b0 && busy === 1'b0) else reportFail("done or busy high after reset");
		readCheck(`REG_MODE, 32'd0, "mode");
		readCheck(`REG_STATUS, 32'd0, "status");
		readCheck(`REG_COUNT, 32'd0, "count");

		// ============================================================
		// exact values and fractions in unsigned truncate mode
		// ============================================================
		runConv(makeWord(1'b0, 0, 52'h12345));
		runConv(makeWord(1'b0, 6, 52'h9999999999999));
		runConv(makeWord(1'b0, -3, 52'h1234567));
		runConv(makeWord(1'b0, -13, 52'h9999999999999));
		// just under 2^64
		runConv(makeWord(1'b0, 7, 52'h1844674407370));
		for (int i = 0; i < RandomCount; i++) begin
			runConv(randomFinite());
		end

		// ============================================================
		// rounding in both signs and both modes
		// ============================================================
		setMode(1'b0, 1'b1);
		runConv(makeWord(1'b0, -1, 52'h25));
		runConv(makeWord(1'b0, -4, 52'h24999));
		setMode(1'b1, 1'b1);
		runConv(makeWord(1'b1, -1, 52'h25));
		runConv(makeWord(1'b1, -4, 52'h24999));
		// carry ripples through the nines
		runConv(makeWord(1'b0, -1, 52'h995));
		setMode(1'b1, 1'b0);
		runConv(makeWord(1'b1, -1, 52'h25));
		runConv(makeWord(1'b0, -1, 52'h25));

		// ============================================================
		// saturation and infinity
		// ============================================================
		runConv(makeWord(1'b0, 6, 52'h9223372036855));
		runConv(makeWord(1'b1, 6, 52'h9223372036855));
		runConv(makeWord(1'b1, 6, 52'h9223372036854));
		runConv(makeWord(1'b0, 30, 52'h1));
		runConv(makeSpecial(1'b0, 1'b0));
		runConv(makeSpecial(1'b1, 1'b0));
		setMode(1'b0, 1'b0);
		runConv(makeWord(1'b0, 7, 52'h1844674407371));
		runConv(makeWord(1'b1, 0, 52'h5));
		runConv(makeSpecial(1'b0, 1'b0));
		readCheck(`REG_STATUS, {30'd0, stickyExp}, "status");

		// NaN and negative zero
		runConv(makeSpecial(1'b0, 1'b1));
		runConv(makeWord(1'b1, 0, 52'h0));
		setMode(1'b1, 1'b0);
		runConv(makeWord(1'b1, -2, 52'h0));
		readCheck(`REG_STATUS, {30'd0, stickyExp}, "status");
		clearStatus(2'b01);
		clearStatus(2'b11);
		readCheck(`REG_COUNT, 32'(issuedCount), "count");

		// ============================================================
		// start while busy is dropped
		// ============================================================
		setMode(1'b0, 1'b0);
		countBefore = issuedCount;
		issueStart(makeWord(1'b0, 0, 52'h777), rec);
		repeat (3) @(negedge clk);
		assert (busy === 1'b1) else reportFail("busy low in the middle of a conversion");
		start = 1'b1;
		operand = makeWord(1'b0, 0, 52'h123);
		@(negedge clk);
		start = 1'b0;
		while (!done) @(negedge clk);
		// leave room for a stray second done
		repeat (40) @(negedge clk);
		readCheck(`REG_COUNT, 32'(countBefore + 1), "count");

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: flist.f
+incdir+design
+incdir+dv
design/dfpPkg.sv
design/convControlRegs.sv
design/dfpDigitAligner.sv
design/bcdToBinary.sv
design/intSaturate.sv
design/dfpToInt.sv
dv/dfpToIntTb.sv

// File: run.sh
#!/bin/sh
# compile and run the dfpToInt testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f flist.f --top-module dfpToIntTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/VdfpToIntTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

# the log decides the verdict
if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi
exit 0
